// File: source/softermax_fmt_pkg.sv
`default_nettype none

package softermax_fmt_pkg;

    // score word, signed Q5.2
    localparam int SCORE_W = 8;
    localparam int FRAC_W = 2;
    localparam int INT_W = SCORE_W - FRAC_W;

    // datapath widths
    localparam int UNORM_W = 16;
    localparam int DEN_W = 20;
    localparam int PROB_W = 8;

    typedef struct packed {
        logic signed [INT_W-1:0] int_part;
        logic [FRAC_W-1:0]       frac;
    } score_fld_t;

    // same 8 bits seen as a number or as its fields
    typedef union packed {
        logic signed [SCORE_W-1:0] raw;
        score_fld_t                fld;
    } score_u;

    // 2^(frac/4) scaled by 16, rounded
    function automatic logic [7:0] pow2_frac(input logic [FRAC_W-1:0] frac);
        logic [7:0] val;
        case (frac)
            2'd0:    val = 8'd16;
            2'd1:    val = 8'd19;
            2'd2:    val = 8'd23;
            default: val = 8'd27;
        endcase
        return val;
    endfunction

endpackage

`default_nettype wire

// File: source/softermax_ctl_pkg.sv
`default_nettype none

package softermax_ctl_pkg;

    // per-lane row life cycle
    // idle -> accum while the row streams in
    // accum -> align for one walk over the buffers
    // align -> ready until the collector has popped every entry
    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,
        LANE_ACCUM = 2'd1,
        LANE_ALIGN = 2'd2,
        LANE_READY = 2'd3
    } lane_state_e;

endpackage

`default_nettype wire

// File: source/lane_drain_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lane_drain_if
    import softermax_fmt_pkg::*;
    import softermax_ctl_pkg::*;
();

    lane_state_e        state;
    // aligned numerator of the current entry
    logic [UNORM_W-1:0] numer;
    logic [DEN_W-1:0]   denom;
    logic               last;
    // one-cycle strobe, advance to next entry
    logic               pop;

    modport lane (
        output state, numer, denom, last,
        input  pop
    );

    modport collector (
        input  state, numer, denom, last,
        output pop
    );

endinterface

`default_nettype wire

// File: source/row_distributor.sv
`timescale 1ns/1ps
`default_nettype none

module row_distributor
    import softermax_fmt_pkg::*;
#(
    parameter int LANES   = 4,
    parameter int ROW_LEN = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  score_u           in_score,
    input  logic [LANES-1:0] lane_idle,
    output logic             in_ready,
    output logic [LANES-1:0] lane_push,
    output score_u           lane_score,
    output logic             lane_first
);

    localparam int CNT_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [CNT_W-1:0] elem_q;
    logic [PTR_W-1:0] ptr_q;
    logic             accept;

    // mid-row the target lane is accumulating and always takes data
    assign in_ready = (elem_q != '0) || lane_idle[ptr_q];
    assign accept = in_valid && in_ready;

    always_comb begin
        lane_push = '0;
        lane_push[ptr_q] = accept;
    end

    assign lane_score = in_score;
    assign lane_first = (elem_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_q <= '0;
            ptr_q <= '0;
        end else if (accept) begin
            if (elem_q == CNT_W'(ROW_LEN - 1)) begin
                elem_q <= '0;
                // row done, move on round-robin
                if (ptr_q == PTR_W'(LANES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= ptr_q + 1'b1;
                end
            end else begin
                elem_q <= elem_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/softermax_lane.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_lane
    import softermax_fmt_pkg::*;
    import softermax_ctl_pkg::*;
#(
    parameter int ROW_LEN = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  score_u     score,
    input  logic       first,
    output logic       idle,
    lane_drain_if.lane drain
);

    localparam int CNT_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;

    lane_state_e state_q;
    logic [CNT_W-1:0] idx_q;
    logic idx_end;
    logic take;

    // running max is one bit wider than int_part, ceil can reach +32
    logic signed [INT_W:0] max_q;
    logic [DEN_W-1:0] den_q;
    logic signed [INT_W:0] loc_max [ROW_LEN];
    logic [UNORM_W-1:0] val_mem [ROW_LEN];

    logic signed [INT_W:0] int_ext;
    logic signed [INT_W:0] ceil_c;
    logic signed [INT_W:0] max_new;
    logic [INT_W:0] u_shift;
    logic [INT_W:0] rise;
    logic [UNORM_W-1:0] u_base;
    logic [UNORM_W-1:0] u_val;
    logic [DEN_W-1:0] den_new;
    logic [INT_W:0] a_shift;

    assign idx_end = (idx_q == CNT_W'(ROW_LEN - 1));
    assign take = push && (state_q == LANE_IDLE || state_q == LANE_ACCUM);

    // ceiling of the integer part
    assign int_ext = {score.fld.int_part[INT_W-1], score.fld.int_part};
    assign ceil_c = int_ext + {{INT_W{1'b0}}, (score.fld.frac != '0)};

    always_comb begin
        if (first) begin
            max_new = ceil_c;
        end else if (ceil_c > max_q) begin
            max_new = ceil_c;
        end else begin
            max_new = max_q;
        end
    end

    // 2^(x - m) as table value times 2^8, shifted by the integer distance
    assign u_base = {pow2_frac(score.fld.frac), 8'h00};
    assign u_shift = max_new - int_ext;
    assign u_val = u_base >> u_shift;

    // rescale old sum when the max rises
    assign rise = first ? '0 : max_new - max_q;
    assign den_new = (first ? '0 : (den_q >> rise)) + DEN_W'(u_val);

    // distance from local max to final row max
    assign a_shift = max_q - loc_max[idx_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LANE_IDLE;
            idx_q <= '0;
        end else begin
            case (state_q)
                LANE_IDLE, LANE_ACCUM: begin
                    if (take) begin
                        if (idx_end) begin
                            state_q <= LANE_ALIGN;
                            idx_q <= '0;
                        end else begin
                            state_q <= LANE_ACCUM;
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                LANE_ALIGN: begin
                    if (idx_end) begin
                        state_q <= LANE_READY;
                        idx_q <= '0;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                LANE_READY: begin
                    if (drain.pop) begin
                        if (idx_end) begin
                            state_q <= LANE_IDLE;
                            idx_q <= '0;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            max_q <= max_new;
            den_q <= den_new;
            loc_max[idx_q] <= max_new;
            val_mem[idx_q] <= u_val;
        end else if (state_q == LANE_ALIGN) begin
            // numerators are rewritten in place
            val_mem[idx_q] <= val_mem[idx_q] >> a_shift;
        end
    end

    assign idle = (state_q == LANE_IDLE);

    assign drain.state = state_q;
    assign drain.numer = val_mem[idx_q];
    assign drain.denom = den_q;
    assign drain.last = idx_end;

endmodule

`default_nettype wire

// File: source/prob_collector.sv
`timescale 1ns/1ps
`default_nettype none

module prob_collector
    import softermax_fmt_pkg::*;
    import softermax_ctl_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    lane_drain_if.collector   drain [LANES],
    output logic              out_valid,
    output logic [PROB_W-1:0] out_prob,
    output logic              out_last
);

    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;
    // numerator carries 8 extra fraction bits for the Q0.8 result
    localparam int QUO_W = UNORM_W + PROB_W;
    localparam int DIV_STEPS = QUO_W;
    localparam int STEP_W = $clog2(DIV_STEPS);

    logic [LANES-1:0] ready_v;
    logic [LANES-1:0] last_v;
    logic [UNORM_W-1:0] numer_v [LANES];
    logic [DEN_W-1:0] denom_v [LANES];

    logic [PTR_W-1:0] ptr_q;
    logic busy_q;
    logic [STEP_W-1:0] step_q;
    logic pop;
    logic step_end;

    logic last_q;
    logic [DEN_W-1:0] den_q;
    logic [DEN_W-1:0] rem_q;
    logic [QUO_W-1:0] dq_q;
    logic [DEN_W:0] rem_shift;
    logic [DEN_W:0] trial;
    logic [QUO_W-1:0] q_next;

    // flatten the interface array, it can only take constant indices
    for (genvar g = 0; g < LANES; g++) begin : g_tap
        assign ready_v[g] = (drain[g].state == LANE_READY);
        assign last_v[g] = drain[g].last;
        assign numer_v[g] = drain[g].numer;
        assign denom_v[g] = drain[g].denom;
        assign drain[g].pop = pop && (ptr_q == PTR_W'(g));
    end

    assign pop = !busy_q && ready_v[ptr_q];
    assign step_end = (step_q == STEP_W'(DIV_STEPS - 1));

    // one restoring step per cycle, quotient bits enter from the right
    assign rem_shift = {rem_q, dq_q[QUO_W-1]};
    assign trial = rem_shift - {1'b0, den_q};
    assign q_next = {dq_q[QUO_W-2:0], ~trial[DEN_W]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            step_q <= '0;
            ptr_q <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
            if (pop) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                if (step_end) begin
                    busy_q <= 1'b0;
                    out_valid <= 1'b1;
                    out_last <= last_q;
                    // lane fully drained, rows stay in arrival order
                    if (last_q) begin
                        ptr_q <= (ptr_q == PTR_W'(LANES - 1)) ? '0 : ptr_q + 1'b1;
                    end
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            den_q <= denom_v[ptr_q];
            last_q <= last_v[ptr_q];
            rem_q <= '0;
            dq_q <= {numer_v[ptr_q], {PROB_W{1'b0}}};
        end else if (busy_q) begin
            rem_q <= trial[DEN_W] ? rem_shift[DEN_W-1:0] : trial[DEN_W-1:0];
            dq_q <= q_next;
        end
        if (busy_q && step_end) begin
            // clip to 255
            out_prob <= (|q_next[QUO_W-1:PROB_W]) ? '1 : q_next[PROB_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/softermax.sv
`timescale 1ns/1ps
`default_nettype none

module softermax
    import softermax_fmt_pkg::*;
#(
    parameter int LANES   = 4,
    parameter int ROW_LEN = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [SCORE_W-1:0] in_score,
    output logic               in_ready,
    output logic               out_valid,
    output logic [PROB_W-1:0]  out_prob,
    output logic               out_last
);

    logic [LANES-1:0] lane_push;
    logic [LANES-1:0] lane_idle;
    score_u           lane_score;
    logic             lane_first;

    lane_drain_if drain [LANES] ();

    row_distributor #(
        .LANES   (LANES),
        .ROW_LEN (ROW_LEN)
    ) i_row_distributor (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_score   (in_score),
        .lane_idle  (lane_idle),
        .in_ready   (in_ready),
        .lane_push  (lane_push),
        .lane_score (lane_score),
        .lane_first (lane_first)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        softermax_lane #(
            .ROW_LEN (ROW_LEN)
        ) i_softermax_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (lane_push[g]),
            .score (lane_score),
            .first (lane_first),
            .idle  (lane_idle[g]),
            .drain (drain[g])
        );
    end

    prob_collector #(
        .LANES (LANES)
    ) i_prob_collector (
        .clk       (clk),
        .rst_n     (rst_n),
        .drain     (drain),
        .out_valid (out_valid),
        .out_prob  (out_prob),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// File: dv/softermax_checker.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_ready,
    input logic out_valid,
    input logic out_last
);

    // each result is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && $past(out_valid)))
        else $error("out_valid high on two consecutive cycles");

    a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid)
        else $error("out_last without out_valid");

    // source must hold off while the target lane is busy
    a_no_push_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> in_ready)
        else $error("in_valid driven while in_ready is low");

    // outputs cleared once reset has been seen on an edge
    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (!out_valid && !out_last))
        else $error("output strobe active during reset");

endmodule

`default_nettype wire

// File: dv/softermax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_tb
    import softermax_fmt_pkg::*;
();

    localparam int LANES = 4;
    localparam int ROW_LEN = 8;
    localparam int NUM_DIR = 8;
    localparam int NUM_RAND = 20;
    localparam int NUM_ROWS = NUM_DIR + NUM_RAND;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (ROW_LEN + ROW_LEN + ROW_LEN * 26) + 200;

    // one row per entry with element 0 in the low byte
    localparam logic [63:0] DIR_SCORES [NUM_DIR] = '{
        64'h0000_0000_0000_0000,
        64'h211C_1712_0F0A_0501,
        64'hF000_1020_3038_3D40,
        64'h0B0B_0B0B_0B0B_0B0B,
        64'hEBF9_C4FF_81D0_E6E1,
        64'h1311_0D06_0703_02FE,
        64'hF3F3_F3F3_F3F3_F3F3,
        64'h7F81_007E_7D7C_807F
    };
    // every element of a flat row expects the same probability
    // -1 leaves the row to the model
    localparam int DIR_EXPECT [NUM_DIR] = '{32, -1, -1, 32, -1, -1, 32, -1};

    logic clk;
    logic rst_n;
    logic in_valid;
    logic [SCORE_W-1:0] in_score;
    logic in_ready;
    logic out_valid;
    logic [PROB_W-1:0] out_prob;
    logic out_last;

    int exp_q [$];
    int exp_prob;
    int out_count = 0;
    int cycle_cnt = 0;
    int stall_cycles = 0;
    int seed;
    int rnd;
    logic [63:0] rand_row;

    softermax #(
        .LANES   (LANES),
        .ROW_LEN (ROW_LEN)
    ) i_softermax (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_score  (in_score),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_prob  (out_prob),
        .out_last  (out_last)
    );

    bind softermax softermax_checker i_softermax_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare(input int actual, input int expected, input string what);
        if (actual != expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s, got %0d expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    // 2^(frac/4) times 16
    function automatic int pow2_weight(input logic [1:0] frac);
        case (frac)
            2'd0:    return 16;
            2'd1:    return 19;
            2'd2:    return 23;
            default: return 27;
        endcase
    endfunction

    function automatic int shr(input int val, input int amt);
        if (amt >= 31) begin
            return 0;
        end
        return val >> amt;
    endfunction

    // online max and sum followed by alignment and Q0.8 division
    task automatic model_row(input logic [63:0] row, input int flat_exp);
        score_u s;
        int ip;
        int c;
        int m;
        int m_prev;
        int d;
        int n;
        int p;
        int loc_m [ROW_LEN];
        int u [ROW_LEN];
        for (int idx = 0; idx < ROW_LEN; idx++) begin
            s.raw = row[8*idx +: 8];
            ip = int'($signed(s.fld.int_part));
            c = ip + ((s.fld.frac != 2'd0) ? 1 : 0);
            if (idx == 0) begin
                m = c;
                d = 0;
            end else begin
                m_prev = m;
                if (c > m) begin
                    m = c;
                end
                d = shr(d, m - m_prev);
            end
            u[idx] = shr(pow2_weight(s.fld.frac) << 8, m - ip);
            d = d + u[idx];
            loc_m[idx] = m;
        end
        for (int idx = 0; idx < ROW_LEN; idx++) begin
            n = shr(u[idx], m - loc_m[idx]);
            p = (n * 256) / d;
            if (p > 255) begin
                p = 255;
            end
            exp_q.push_back((flat_exp >= 0) ? flat_exp : p);
        end
    endtask

    // first element waits for an idle target lane and the rest stream back to back
    task automatic send_row(input logic [63:0] row);
        @(negedge clk);
        while (!in_ready) begin
            stall_cycles = stall_cycles + 1;
            @(negedge clk);
        end
        for (int idx = 0; idx < ROW_LEN; idx++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_score <= row[8*idx +: 8];
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("result strobe arrived with no result expected");
            end else begin
                exp_prob = exp_q.pop_front();
                compare(int'(out_prob), exp_prob,
                        $sformatf("probability at output %0d", out_count));
                compare(int'(out_last), (out_count % ROW_LEN == ROW_LEN - 1) ? 1 : 0,
                        $sformatf("last flag at output %0d", out_count));
                out_count <= out_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d results",
                                        cycle_cnt, out_count, NUM_ROWS * ROW_LEN));
        end
    end

    initial begin
        seed = 32'h9f8b;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_score = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare(int'(in_ready), 1, "in_ready after reset");

        // directed rows go in back to back and fill every lane
        for (int r = 0; r < NUM_DIR; r++) begin
            model_row(DIR_SCORES[r], DIR_EXPECT[r]);
            send_row(DIR_SCORES[r]);
        end
        // more rows than lanes must hold the source off
        compare(int'(stall_cycles > 0), 1, "in_ready stall during directed rows");

        for (int r = 0; r < NUM_RAND; r++) begin
            for (int k = 0; k < ROW_LEN; k++) begin
                rnd = $random(seed);
                rand_row[8*k +: 8] = rnd[7:0];
            end
            model_row(rand_row, -1);
            send_row(rand_row);
        end

        while (out_count < NUM_ROWS * ROW_LEN) begin
            @(negedge clk);
        end
        // stray outputs would show up here
        repeat (60) @(negedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/softermax_fmt_pkg.sv
source/softermax_ctl_pkg.sv
source/lane_drain_if.sv
source/row_distributor.sv
source/softermax_lane.sv
source/prob_collector.sv
source/softermax.sv
dv/softermax_checker.sv
dv/softermax_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module softermax_tb -f vlog.f -o softermax_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/softermax_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0
